// File: filelist.f
hdl/mopshub_pkg.sv
hdl/bus_link_if.sv
hdl/downlink_dispatch.sv
hdl/can_serializer.sv
hdl/can_deserializer.sv
hdl/uplink_arbiter.sv
hdl/mopshub_core.sv
tests/mopshub_chk.sv
tests/tb_mopshub_top.sv

// File: hdl/bus_link_if.sv
`timescale 1ns/1ns
`default_nettype none

interface bus_link_if
  import mopshub_pkg::*;
();

  // Single-cycle strobe, fields valid while it is high
  logic              stb;
  logic [BUS_W-1:0]  bus_sel;
  logic [COB_W-1:0]  cob_id;
  logic              rtr;
  logic [DATA_W-1:0] data;

  modport src (
    output stb, bus_sel, cob_id, rtr, data
  );

  modport dst (
    input  stb, bus_sel, cob_id, rtr, data
  );

endinterface

`default_nettype wire

// File: hdl/can_deserializer.sv
`timescale 1ns/1ns
`default_nettype none

module can_deserializer
  import mopshub_pkg::*;
(
  input  logic               clk_40,
  input  logic               rst,
  input  logic               rx,
  output logic               frame_stb,
  output logic [FRAME_W-1:0] frame
);

  logic               rx_q;
  logic               active;
  logic [CNT_W-1:0]   bit_cnt;
  logic [FRAME_W-1:0] shift;
  logic               stop_slot;

  // Bit after the last payload bit
  assign stop_slot = (bit_cnt == CNT_W'(FRAME_W));

  always_ff @(posedge clk_40)
  begin
    if (!rst)
    begin
      rx_q      <= 1'b1;
      active    <= 1'b0;
      bit_cnt   <= '0;
      frame_stb <= 1'b0;
    end
    else
    begin
      rx_q      <= rx;
      frame_stb <= 1'b0;
      if (!active)
      begin
        // Start bit is a fall from an idle line
        if (rx_q && !rx)
        begin
          active  <= 1'b1;
          bit_cnt <= '0;
        end
      end
      else if (stop_slot)
      begin
        active    <= 1'b0;
        frame_stb <= rx;    // low stop bit discards the frame
      end
      else
        bit_cnt <= bit_cnt + 1'b1;
    end
  end

  // LSB arrives first, so shift in from the top
  always_ff @(posedge clk_40)
  begin
    if (active && !stop_slot)
      shift <= {rx, shift[FRAME_W-1:1]};
  end

  assign frame = shift;

endmodule

`default_nettype wire

// File: hdl/can_serializer.sv
`timescale 1ns/1ns
`default_nettype none

module can_serializer
  import mopshub_pkg::*;
(
  input  logic               clk_40,
  input  logic               rst,
  bus_link_if.dst            link,
  output logic               busy,
  output logic [N_BUSES-1:0] tx
);

  logic [FRAME_CYCLES-1:0] shift;
  logic [CNT_W-1:0]        bit_cnt;
  logic [BUS_W-1:0]        sel;

  always_ff @(posedge clk_40)
  begin
    if (!rst)
    begin
      busy    <= 1'b0;
      bit_cnt <= '0;
      tx      <= '1;
    end
    else
    begin
      // Lines idle high unless selected
      tx <= '1;
      if (busy)
      begin
        tx[sel] <= shift[0];
        if (bit_cnt == CNT_W'(FRAME_CYCLES - 1))
        begin
          busy    <= 1'b0;
          bit_cnt <= '0;
        end
        else
          bit_cnt <= bit_cnt + 1'b1;
      end
      else if (link.stb)
      begin
        busy    <= 1'b1;
        bit_cnt <= '0;
      end
    end
  end

  // Line order from bit 0 up: start, data, rtr, cob id, stop
  always_ff @(posedge clk_40)
  begin
    if (!busy && link.stb)
    begin
      shift <= {1'b1, link.cob_id, link.rtr, link.data, 1'b0};
      sel   <= link.bus_sel;
    end
    else if (busy)
      shift <= {1'b1, shift[FRAME_CYCLES-1:1]};
  end

endmodule

`default_nettype wire

// File: hdl/downlink_dispatch.sv
`timescale 1ns/1ns
`default_nettype none

module downlink_dispatch
  import mopshub_pkg::*;
(
  input  logic               clk_40,
  input  logic               rst,
  input  logic               down_stb,
  input  hub_msg_u           down_word,
  input  logic               busy,
  bus_link_if.src            link,
  output logic               status_stb,
  output logic [N_BUSES-1:0] power_en,
  output logic [7:0]         drop_cnt
);

  logic             is_cmd;
  logic             bus_valid;
  logic [BUS_W-1:0] bus;
  logic             tx_busy;
  logic             accept;
  logic             drop;

  // Reserved cob id marks a command to the hub
  assign is_cmd    = (down_word.cmd.cob_id == HUB_COB);
  assign bus_valid = (down_word.frame.bus_id < 8'(N_BUSES));
  assign bus       = down_word.frame.bus_id[BUS_W-1:0];

  // A frame registered last cycle has not reached the serializer yet
  assign tx_busy = busy | link.stb;

  assign accept = down_stb & ~is_cmd & bus_valid & power_en[bus] & ~tx_busy;
  assign drop   = down_stb & ~is_cmd & ~accept;

  always_ff @(posedge clk_40)
  begin
    if (!rst)
    begin
      power_en   <= '0;
      status_stb <= 1'b0;
      drop_cnt   <= 8'd0;
      link.stb   <= 1'b0;
    end
    else
    begin
      status_stb <= 1'b0;
      link.stb   <= accept;
      if (down_stb && is_cmd)
      begin
        case (down_word.cmd.opcode)
          OP_POWER_ON:
            if (bus_valid)
              power_en[bus] <= 1'b1;
          OP_POWER_OFF:
            if (bus_valid)
              power_en[bus] <= 1'b0;
          OP_STATUS:
            status_stb <= 1'b1;
          default:
            ;
        endcase
      end
      // Saturates at 255
      if (drop && drop_cnt != 8'hff)
        drop_cnt <= drop_cnt + 8'd1;
    end
  end

  // Frame fields for the serializer
  always_ff @(posedge clk_40)
  begin
    if (accept)
    begin
      link.bus_sel <= bus;
      link.cob_id  <= down_word.frame.cob_id;
      link.rtr     <= down_word.frame.rtr;
      link.data    <= down_word.frame.data;
    end
  end

endmodule

`default_nettype wire

// File: hdl/mopshub_core.sv
`timescale 1ns/1ns
`default_nettype none

module mopshub_core
  import mopshub_pkg::*;
(
  input  logic               clk_40,
  input  logic               rst,
  input  logic               down_stb,
  input  logic [MSG_W-1:0]   down_word,
  input  logic [N_BUSES-1:0] rx,
  output logic               up_stb,
  output logic [MSG_W-1:0]   up_word,
  output logic [N_BUSES-1:0] tx,
  output logic [N_BUSES-1:0] power_bus_en,
  output logic [7:0]         drop_cnt
);

  hub_msg_u                        down_msg;
  hub_msg_u                        up_msg;
  logic                            busy;
  logic                            status_stb;
  logic [N_BUSES-1:0]              rx_stb;
  logic [N_BUSES-1:0][FRAME_W-1:0] rx_frame;

  bus_link_if link ();

  assign down_msg = down_word;
  assign up_word  = up_msg;

  downlink_dispatch u_dispatch (
    .clk_40     (clk_40),
    .rst        (rst),
    .down_stb   (down_stb),
    .down_word  (down_msg),
    .busy       (busy),
    .link       (link.src),
    .status_stb (status_stb),
    .power_en   (power_bus_en),
    .drop_cnt   (drop_cnt)
  );

  can_serializer u_serializer (
    .clk_40 (clk_40),
    .rst    (rst),
    .link   (link.dst),
    .busy   (busy),
    .tx     (tx)
  );

  // One receiver per bus line
  for (genvar i = 0; i < N_BUSES; i++)
  begin : g_rx
    can_deserializer u_deserializer (
      .clk_40    (clk_40),
      .rst       (rst),
      .rx        (rx[i]),
      .frame_stb (rx_stb[i]),
      .frame     (rx_frame[i])
    );
  end

  uplink_arbiter u_arbiter (
    .clk_40     (clk_40),
    .rst        (rst),
    .rx_stb     (rx_stb),
    .rx_frame   (rx_frame),
    .status_stb (status_stb),
    .power_en   (power_bus_en),
    .up_stb     (up_stb),
    .up_word    (up_msg)
  );

endmodule

`default_nettype wire

// File: hdl/mopshub_pkg.sv
`default_nettype none

package mopshub_pkg;

  // Hub sizes
  localparam int N_BUSES      = 8;
  localparam int BUS_W        = 3;
  localparam int MSG_W        = 76;
  localparam int COB_W        = 11;
  localparam int DATA_W       = 56;
  localparam int FRAME_W      = 68;

  // Start bit, payload, stop bit
  localparam int FRAME_CYCLES = 70;
  localparam int CNT_W        = $clog2(FRAME_CYCLES);

  // Cob id reserved for commands addressed to the hub
  localparam logic [COB_W-1:0] HUB_COB = 11'h000;

  // Hub command opcodes
  localparam logic [3:0] OP_POWER_ON  = 4'h1;
  localparam logic [3:0] OP_POWER_OFF = 4'h2;
  localparam logic [3:0] OP_STATUS    = 4'h3;

  // Downlink word seen as a bus frame
  typedef struct packed {
    logic [7:0]        bus_id;
    logic [COB_W-1:0]  cob_id;
    logic              rtr;
    logic [DATA_W-1:0] data;
  } frame_view;

  // Same word seen as a hub command
  typedef struct packed {
    logic [7:0]       bus_id;
    logic [COB_W-1:0] cob_id;
    logic [3:0]       opcode;
    logic [52:0]      arg;
  } cmd_view;

  // Both views share bus_id and cob_id at the same bit positions,
  // so the cob id alone tells which view applies
  typedef union packed {
    frame_view frame;
    cmd_view   cmd;
  } hub_msg_u;

endpackage

`default_nettype wire

// File: hdl/uplink_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module uplink_arbiter
  import mopshub_pkg::*;
(
  input  logic                            clk_40,
  input  logic                            rst,
  input  logic [N_BUSES-1:0]              rx_stb,
  input  logic [N_BUSES-1:0][FRAME_W-1:0] rx_frame,
  input  logic                            status_stb,
  input  logic [N_BUSES-1:0]              power_en,
  output logic                            up_stb,
  output hub_msg_u                        up_word
);

  logic [N_BUSES-1:0] pending;
  logic [FRAME_W-1:0] slot [N_BUSES];
  logic               status_pend;
  logic [BUS_W-1:0]   last_gnt;
  logic               gnt_valid;
  logic [BUS_W-1:0]   gnt;
  logic [N_BUSES-1:0] clr_mask;
  hub_msg_u           status_word;
  hub_msg_u           frame_word;

  // Round-robin search starting one past the last bus granted;
  // descending loop so the nearest pending bus wins
  always_comb
  begin
    gnt_valid = 1'b0;
    gnt       = last_gnt;
    for (int k = N_BUSES; k >= 1; k--)
    begin
      if (pending[last_gnt + BUS_W'(k)])
      begin
        gnt_valid = 1'b1;
        gnt       = last_gnt + BUS_W'(k);
      end
    end
  end

  // Status reply takes the cycle ahead of any frame
  always_comb
  begin
    clr_mask = '0;
    if (!status_pend && gnt_valid)
      clr_mask[gnt] = 1'b1;
  end

  always_comb
  begin
    status_word.cmd.bus_id = 8'd0;
    status_word.cmd.cob_id = HUB_COB;
    status_word.cmd.opcode = OP_STATUS;
    status_word.cmd.arg    = 53'(power_en);
  end

  // Slot holds cob id, rtr and data in frame_view order
  assign frame_word = {8'(gnt), slot[gnt]};

  always_ff @(posedge clk_40)
  begin
    if (!rst)
    begin
      pending     <= '0;
      status_pend <= 1'b0;
      last_gnt    <= BUS_W'(N_BUSES - 1);
      up_stb      <= 1'b0;
    end
    else
    begin
      up_stb      <= status_pend | gnt_valid;
      status_pend <= status_stb;
      // A new frame keeps its slot pending even when granted this cycle
      pending     <= (pending & ~clr_mask) | rx_stb;
      if (!status_pend && gnt_valid)
        last_gnt <= gnt;
    end
  end

  always_ff @(posedge clk_40)
  begin
    up_word <= status_pend ? status_word : frame_word;
    for (int i = 0; i < N_BUSES; i++)
    begin
      if (rx_stb[i])
        slot[i] <= rx_frame[i];
    end
  end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build with Verilator and run from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f filelist.f \
  --top-module tb_mopshub_top -o tb_sim &&
  ./obj_dir/tb_sim | tee /dev/stderr | grep -qx "test passed" &&
  echo "Simulation PASSED" ||
  { echo "Simulation FAILED"; exit 1; }

// File: tests/mopshub_chk.sv
`timescale 1ns/1ns
`default_nettype none

module mopshub_chk
  import mopshub_pkg::*;
(
  input logic               clk_40,
  input logic               rst,
  input logic               up_stb,
  input logic [MSG_W-1:0]   up_word,
  input logic [N_BUSES-1:0] tx,
  input logic [7:0]         drop_cnt
);

  // Back to back strobes carry different words
  a_up_word_fresh : assert property (@(posedge clk_40) disable iff (!rst)
    (up_stb && $past(up_stb)) |-> (up_word != $past(up_word)))
    else $error("uplink strobe held the same word for two cycles");

  // One shared serializer
  a_one_tx_low : assert property (@(posedge clk_40) disable iff (!rst)
    $onehot0(~tx))
    else $error("more than one tx line is low");

  a_drop_up_only : assert property (@(posedge clk_40) disable iff (!rst)
    $past(rst) |-> (drop_cnt >= $past(drop_cnt)))
    else $error("drop_cnt decreased");

endmodule

bind mopshub_core mopshub_chk u_chk (
  .clk_40   (clk_40),
  .rst      (rst),
  .up_stb   (up_stb),
  .up_word  (up_word),
  .tx       (tx),
  .drop_cnt (drop_cnt)
);

`default_nettype wire

// File: tests/mopshub_stimulus.mem
// Columns: test, gap in cycles to the next word, drop_cnt after the word,
// downlink word, expected uplink word (0 when no reply), all hex
// Test 2: bus 1 on, bus 6 on, bus 1 off, status
02 0A 00 0100020000000000000 0
02 0A 00 0600020000000000000 0
02 0A 00 0100040000000000000 0
02 0A 00 0000060000000000000 0000060000000000040
// Test 3: power buses 2 and 5, then echo frames on 6, 2 and 5
03 0A 00 0200020000000000000 0
03 0A 00 0500020000000000000 0
03 5A 00 06C0211223344556677 06B0211223344556677
03 5A 00 02C05A5A5A5A55A5A5A 02B05A5A5A5A55A5A5A
03 5A 00 05FFE0123456789ABCD 05EFE0123456789ABCD
// Test 4: unpowered bus 3, bus id 9, bus 1 after power off
04 5A 01 03C0200000000000001 0
04 5A 02 09C0200000000000002 0
04 5A 03 01C0200000000000003 0
// Test 5: second frame lands while the serializer is busy
05 0A 03 06C02CAFE0000000001 06B02CAFE0000000001
05 5A 04 06C02BEEF0000000002 0
// Test 6: echo on bus 2 overlaps the request on bus 5
06 50 04 023020000000000BEEF 022020000000000BEEF
06 5A 04 0530BFEDCBA98765432 0520BFEDCBA98765432

// File: tests/tb_mopshub_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mopshub_top
  import mopshub_pkg::*;
();

  localparam int MAX_WORDS   = 64;
  localparam int UPLINK_WAIT = 2 * FRAME_CYCLES + 40;

  logic               clk_40;
  logic               rst;
  logic               down_stb;
  logic [MSG_W-1:0]   down_word;
  wire  [N_BUSES-1:0] rx;
  logic               up_stb;
  logic [MSG_W-1:0]   up_word;
  logic [N_BUSES-1:0] tx;
  logic [N_BUSES-1:0] power_bus_en;
  logic [7:0]         drop_cnt;

  // Five columns per downlink word
  logic [MSG_W-1:0]   stim [0:5*MAX_WORDS-1];
  logic [MSG_W-1:0]   got_q [$];
  logic [MSG_W-1:0]   pool [$];
  logic [MSG_W-1:0]   exp_q [$];
  int                 tx_starts = 0;
  int                 taken = 0;
  int                 cycle_cnt = 0;
  int                 cycle_limit = 0;
  int                 errors = 0;
  int                 tests_run = 0;
  int                 tests_failed = 0;
  int                 test_err;
  string              cur_name;
  string              test_names [7] = '{"unknown", "reset state", "power and status",
    "echo round trip", "unpowered or invalid bus", "busy drop", "concurrent replies"};

  mopshub_core DUT (
    .clk_40       (clk_40),
    .rst          (rst),
    .down_stb     (down_stb),
    .down_word    (down_word),
    .rx           (rx),
    .up_stb       (up_stb),
    .up_word      (up_word),
    .tx           (tx),
    .power_bus_en (power_bus_en),
    .drop_cnt     (drop_cnt)
  );

  initial
  begin
    clk_40 = 1'b0;
    forever #2 clk_40 = ~clk_40;
  end

  // Bus node models, each echoes a request with cob id lowered by 0x080
  for (genvar b = 0; b < N_BUSES; b++)
  begin : g_node
    logic                    rx_line;
    logic [FRAME_W-1:0]      req;
    logic [FRAME_CYCLES-1:0] echo_bits;

    assign rx[b] = rx_line;

    initial
    begin
      rx_line = 1'b1;
      forever
      begin
        @(negedge clk_40);
        if (rst && !tx[b])
        begin
          // Start bit of a request frame
          tx_starts++;
          for (int i = 0; i < FRAME_W; i++)
          begin
            @(negedge clk_40);
            req[i] = tx[b];
          end
          @(negedge clk_40);
          // No reply to a frame with a low stop bit
          if (tx[b])
          begin
            echo_bits = {1'b1, req[FRAME_W-1 -: COB_W] - 11'h080, req[DATA_W:0], 1'b0};
            repeat (5) @(posedge clk_40);
            for (int i = 0; i < FRAME_CYCLES; i++)
            begin
              @(posedge clk_40);
              rx_line <= echo_bits[i];
            end
          end
        end
      end
    end
  end

  // Uplink words, sampled mid-cycle
  always @(negedge clk_40)
  begin
    if (rst && up_stb)
      got_q.push_back(up_word);
  end

  always @(posedge clk_40)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit)
    begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("test failed");
      $finish;
    end
  end

  task automatic check_equal(input string what, input logic [MSG_W-1:0] expected,
                             input logic [MSG_W-1:0] actual);
    assert (actual === expected)
    else
    begin
      $display("[ERROR] %s %s: expected %h, actual %h", cur_name, what, expected, actual);
      test_err++;
    end
  endtask

  task automatic begin_test(input int t);
    test_err = 0;
    cur_name = (t >= 1 && t <= 6) ? test_names[t] : test_names[0];
  endtask

  task automatic finish_test(input int t);
    $display("Test %0d %s: %s", t, cur_name, (test_err == 0) ? "ok" : "FAILED");
    tests_run++;
    if (test_err != 0)
      tests_failed++;
    errors += test_err;
  endtask

  // One strobe, then idle until gap cycles after it
  task automatic send_word(input logic [MSG_W-1:0] word, input int gap);
    @(posedge clk_40);
    down_stb  <= 1'b1;
    down_word <= word;
    @(posedge clk_40);
    down_stb  <= 1'b0;
    repeat (gap - 2) @(posedge clk_40);
    @(negedge clk_40);
  endtask

  // Matches arrivals against expected words in any order
  task automatic wait_uplink();
    int waited;
    bit hit;
    waited = 0;
    do
    begin
      @(posedge clk_40);
      waited++;
      while (taken < got_q.size())
      begin
        pool.push_back(got_q[taken]);
        taken++;
      end
      for (int i = exp_q.size() - 1; i >= 0; i--)
      begin
        hit = 1'b0;
        for (int j = 0; j < pool.size() && !hit; j++)
        begin
          if (pool[j] == exp_q[i])
          begin
            pool.delete(j);
            hit = 1'b1;
          end
        end
        if (hit)
          exp_q.delete(i);
      end
    end
    while (exp_q.size() > 0 && waited < UPLINK_WAIT);
    assert (exp_q.size() == 0)
    else
    begin
      $display("%s: %0d expected uplink words never arrived", cur_name, exp_q.size());
      test_err++;
    end
    assert (pool.size() == 0)
    else
    begin
      $display("%s: %0d uplink words arrived that no request asked for", cur_name, pool.size());
      test_err++;
    end
    exp_q.delete();
    pool.delete();
  endtask

  initial
  begin
    int       n_words;
    int       idx;
    int       test;
    int       starts_before;
    int       tx_expected;
    hub_msg_u w;
    hub_msg_u expect_w;
    rst       = 1'b0;
    down_stb  = 1'b0;
    down_word = '0;
    $readmemh("tests/mopshub_stimulus.mem", stim);
    n_words = 0;
    while (n_words < MAX_WORDS && stim[5*n_words] != '0)
      n_words++;
    cycle_limit = n_words * 120 + 200;
    repeat (2) @(posedge clk_40);
    rst <= 1'b1;
    @(negedge clk_40);
    begin_test(1);
    check_equal("up_stb", MSG_W'(0), MSG_W'(up_stb));
    check_equal("tx", MSG_W'({N_BUSES{1'b1}}), MSG_W'(tx));
    check_equal("power_bus_en", MSG_W'(0), MSG_W'(power_bus_en));
    check_equal("drop_cnt", MSG_W'(0), MSG_W'(drop_cnt));
    finish_test(1);
    idx = 0;
    while (idx < n_words)
    begin
      test = int'(stim[5*idx]);
      begin_test(test);
      starts_before = tx_starts;
      tx_expected   = 0;
      while (idx < n_words && int'(stim[5*idx]) == test)
      begin
        w        = stim[5*idx+3];
        expect_w = stim[5*idx+4];
        send_word(w, int'(stim[5*idx+1]));
        check_equal("drop_cnt", stim[5*idx+2], MSG_W'(drop_cnt));
        if (expect_w != '0)
          exp_q.push_back(expect_w);
        // Every echoed frame crossed a tx line once
        if (expect_w != '0 && expect_w.frame.cob_id != HUB_COB)
          tx_expected++;
        if (w.cmd.cob_id == HUB_COB && w.cmd.opcode == OP_STATUS)
          check_equal("power_bus_en", MSG_W'(expect_w.cmd.arg[N_BUSES-1:0]),
                      MSG_W'(power_bus_en));
        idx++;
      end
      wait_uplink();
      check_equal("tx frames", MSG_W'(tx_expected), MSG_W'(tx_starts - starts_before));
      finish_test(test);
    end
    $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire
